//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f atc_tower.f --top-module atc_tb
	@out=$$(./obj_dir/Vatc_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- atc_tower.f
+incdir+common
common/atc_msg_pkg.sv
common/atc_ctrl_pkg.sv
hw/atc_fifo.sv
hw/atc_tx_sender.sv
hw/tower_ctrl/runway_table.sv
hw/tower_ctrl/atc_request_ctrl.sv
hw/atc_tower.sv
dv/atc_tb_clock.sv
dv/atc_tb.sv

//--- common/atc_ctrl_pkg.sv
//////////////////////////////////////////////////
// Request controller internals
//////////////////////////////////////////////////

`default_nettype none

package atc_ctrl_pkg;

  typedef enum logic [2:0] {IDLE, DECODE, REPLY, PICK, CLEAR} ctrl_state_t;

  // Kind of reply the controller is about to queue
  typedef enum logic [1:0] {
    R_HOLD,
    R_DIVERT,
    R_SAY_AGAIN,
    R_CLEAR
  } reply_kind_t;

endpackage

`default_nettype wire

//--- common/atc_macros.svh
//////////////////////////////////////////////////
// Tower controller widths and depths
// Shared by the RTL and the testbench
//////////////////////////////////////////////////

`ifndef ATC_MACROS_SVH
`define ATC_MACROS_SVH

// Message field widths
`define ATC_PLANE_ID_W 4
`define ATC_MSG_W 9

// Every FIFO in the tower uses this depth
`define ATC_FIFO_DEPTH 4

// Upper bound on any testbench wait, in cycles
`define ATC_TIMEOUT 200

`endif

//--- common/atc_msg_pkg.sv
//////////////////////////////////////////////////
// Tower message format
// Message types and the 9-bit message layout
//////////////////////////////////////////////////

`default_nettype none

`include "atc_macros.svh"

package atc_msg_pkg;

  // Requests from planes and replies from the tower share one space
  typedef enum logic [2:0] {
    T_REQUEST   = 3'd0,
    T_DECLARE   = 3'd1,
    T_EMERGENCY = 3'd2,
    T_CLEAR     = 3'd3,
    T_HOLD      = 3'd4,
    T_SAY_AGAIN = 3'd5,
    T_DIVERT    = 3'd6
  } msg_type_t;

  typedef struct packed {
    logic [`ATC_PLANE_ID_W-1:0] plane_id;
    msg_type_t                  msg_type;
    logic [1:0]                 action;
  } msg_t;

endpackage

`default_nettype wire

//--- dv/atc_tb.sv
//////////////////////////////////////////////////
// Tower controller testbench
// Directed tests on requests, releases, queue
// overflow, back-pressure and alternation
//////////////////////////////////////////////////

`default_nettype none

`include "atc_macros.svh"

module atc_tb
  import atc_msg_pkg::*;
();

  logic clock, reset_n;
  msg_t uart_rx_data, uart_tx_data;
  logic uart_rx_valid, uart_tx_ready, uart_tx_send, busy;
  msg_t replies[$];
  int   clear_count;

  atc_tb_clock #(.PERIOD(8), .RESET_CYCLES(10)) i_clock (.clock, .reset_n);

  atc_tower i_atc_tower (
    .clock, .reset_n, .uart_rx_data, .uart_rx_valid, .uart_tx_data,
    .uart_tx_ready, .uart_tx_send, .busy
  );

  // Replies captured mid-cycle, away from the driving edge
  always @(negedge clock) begin
    if (reset_n && uart_tx_send) begin
      replies.push_back(uart_tx_data);
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  function automatic msg_t build_msg(int id, logic [2:0] mtype, logic [1:0] action);
    msg_t m;
    m = {id[`ATC_PLANE_ID_W-1:0], mtype, action};
    return m;
  endfunction

  task automatic send_msg(msg_t m);
    @(posedge clock);
    uart_rx_data  <= m;
    uart_rx_valid <= 1'b1;
    @(posedge clock);
    uart_rx_valid <= 1'b0;
  endtask

  task automatic wait_for_reset();
    int waited;
    waited = 0;
    while (!reset_n && waited < `ATC_TIMEOUT) begin
      @(posedge clock);
      waited++;
    end
    if (!reset_n) begin
      $display("Reset was never released");
      $display("CHECKS FAILED");
      $fatal(1, "reset stuck");
    end else begin
      @(posedge clock);
    end
  endtask

  task automatic next_reply(output msg_t r);
    int waited;
    waited = 0;
    while (replies.size() == 0 && waited < `ATC_TIMEOUT) begin
      @(posedge clock);
      waited++;
    end
    if (replies.size() == 0) begin
      $display("No reply from the tower within %0d cycles at %0t", waited, $time);
      $display("CHECKS FAILED");
      $fatal(1, "reply timeout");
    end else begin
      r = replies.pop_front();
    end
  endtask

  task automatic expect_reply(int id, logic [2:0] mtype, logic [1:0] action);
    msg_t r;
    next_reply(r);
    check_value("uart_tx_data.plane_id", r.plane_id, id);
    check_value("uart_tx_data.msg_type", r.msg_type, mtype);
    check_value("uart_tx_data.action", r.action, action);
  endtask

  // Every clearance flips the takeoff/landing preference
  task automatic expect_clear(int id, int rw);
    expect_reply(id, T_CLEAR, rw[1:0]);
    clear_count++;
  endtask

  task automatic expect_silence(int cycles);
    repeat (cycles) @(posedge clock);
    check_value("pending replies", replies.size(), 0);
  endtask

  task automatic request(int id, bit landing);
    send_msg(build_msg(id, T_REQUEST, {landing, 1'b0}));
  endtask

  task automatic declare(int id, int rw);
    send_msg(build_msg(id, T_DECLARE, {1'b0, rw[0]}));
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_single_takeoff();
    request(1, 1'b0);
    expect_reply(1, T_HOLD, 2'd0);
    expect_clear(1, 0);
  endtask

  task automatic test_runway_release();
    request(2, 1'b0);
    expect_reply(2, T_HOLD, 2'd0);
    expect_clear(2, 1);
    request(3, 1'b1);
    expect_reply(3, T_HOLD, 2'd0);
    expect_silence(40);
    // Plane 2 does not hold runway 0
    declare(2, 0);
    expect_silence(40);
    declare(1, 0);
    expect_clear(3, 0);
  endtask

  task automatic test_say_again();
    send_msg(build_msg(5, 3'd7, 2'd0));
    expect_reply(5, T_SAY_AGAIN, 2'd0);
    send_msg(build_msg(5, T_EMERGENCY, 2'd0));
    expect_reply(5, T_SAY_AGAIN, 2'd0);
  endtask

  task automatic test_queue_full();
    for (int id = 10; id < 14; id++) begin
      request(id, 1'b0);
      expect_reply(id, T_HOLD, 2'd0);
    end
    request(14, 1'b0);
    expect_reply(14, T_DIVERT, 2'd0);
  endtask

  task automatic test_back_pressure();
    // Drain the four queued takeoffs, one per release
    declare(3, 0);
    expect_clear(10, 0);
    declare(2, 1);
    expect_clear(11, 1);
    declare(10, 0);
    expect_clear(12, 0);
    declare(11, 1);
    expect_clear(13, 1);
    request(6, 1'b0);
    expect_reply(6, T_HOLD, 2'd0);
    declare(12, 0);
    expect_clear(6, 0);
    request(7, 1'b0);
    expect_reply(7, T_HOLD, 2'd0);
    declare(13, 1);
    expect_clear(7, 1);
    @(posedge clock);
    uart_tx_ready <= 1'b0;
    for (int id = 1; id < 4; id++) begin
      send_msg(build_msg(id, 3'd7, 2'd0));
    end
    expect_silence(40);
    @(posedge clock);
    uart_tx_ready <= 1'b1;
    for (int id = 1; id < 4; id++) begin
      expect_reply(id, T_SAY_AGAIN, 2'd0);
    end
  endtask

  task automatic test_alternation();
    int first;
    int second;
    // One more clearance on runway 1 so the count is even
    request(4, 1'b0);
    expect_reply(4, T_HOLD, 2'd0);
    declare(7, 1);
    expect_clear(4, 1);
    request(8, 1'b0);
    expect_reply(8, T_HOLD, 2'd0);
    request(9, 1'b1);
    expect_reply(9, T_HOLD, 2'd0);
    // Takeoff is favoured after an even number of clearances
    first  = (clear_count % 2 == 0) ? 8 : 9;
    second = (first == 8) ? 9 : 8;
    declare(6, 0);
    expect_clear(first, 0);
    declare(first, 0);
    expect_clear(second, 0);
  endtask

  initial begin
    uart_rx_data  = '0;
    uart_rx_valid = 1'b0;
    uart_tx_ready = 1'b1;
    clear_count   = 0;
    wait_for_reset();
    check_value("busy", busy, 0);
    check_value("uart_tx_send", uart_tx_send, 0);
    test_single_takeoff();
    test_runway_release();
    test_say_again();
    test_queue_full();
    test_back_pressure();
    test_alternation();
    expect_silence(20);
    check_value("busy", busy, 0);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/atc_tb_clock.sv
//////////////////////////////////////////////////
// Testbench clock and reset generator
//////////////////////////////////////////////////

`default_nettype none

module atc_tb_clock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic clock,
  output logic reset_n
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // Reset released on a rising edge
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- hw/atc_fifo.sv
//////////////////////////////////////////////////
// Synchronous FIFO
// Circular buffer, head visible without a pop
//////////////////////////////////////////////////

`default_nettype none

module atc_fifo #(
  parameter int WIDTH = 9,
  parameter int DEPTH = 4
) (
  input  logic             clock,
  input  logic             reset_n,
  input  logic [WIDTH-1:0] data_in,
  input  logic             push,
  input  logic             pop,
  output logic [WIDTH-1:0] head,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0]     mem [DEPTH];
  logic [PTR_W-1:0]     rd_ptr, wr_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                 do_push, do_pop;

  assign full    = (count == DEPTH);
  assign empty   = (count == 0);
  assign head    = mem[rd_ptr];
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Pointers wrap explicitly so DEPTH need not be a power of two
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= data_in;
    end
  end

endmodule

`default_nettype wire

//--- hw/atc_tower.sv
//////////////////////////////////////////////////
// Two-runway tower controller, top level
// UART messages in, HOLD/CLEAR/DIVERT replies out
//////////////////////////////////////////////////

`default_nettype none

`include "atc_macros.svh"

module atc_tower
  import atc_msg_pkg::*;
(
  input  logic clock,
  input  logic reset_n,
  input  msg_t uart_rx_data,
  input  logic uart_rx_valid,
  output msg_t uart_tx_data,
  input  logic uart_tx_ready,
  output logic uart_tx_send,
  output logic busy
);

  // Receive path
  msg_t rx_head;
  logic rx_empty, rx_pop;

  // Takeoff and landing queues
  logic [`ATC_PLANE_ID_W-1:0] push_id, takeoff_head, landing_head;
  logic takeoff_push, takeoff_pop, takeoff_full, takeoff_empty;
  logic landing_push, landing_pop, landing_full, landing_empty;

  // Runway table
  logic [1:0] runway_active;
  logic       lock, release_req, runway;
  logic [`ATC_PLANE_ID_W-1:0] lock_id;

  // Reply path
  msg_t reply, reply_head;
  logic reply_push, reply_pop, reply_full, reply_empty;

  //////////////////////////////////////////////////
  // Queues
  //////////////////////////////////////////////////

  atc_fifo #(.WIDTH(`ATC_MSG_W), .DEPTH(`ATC_FIFO_DEPTH)) rx_fifo (
    .clock, .reset_n, .data_in(uart_rx_data), .push(uart_rx_valid), .pop(rx_pop),
    .head(rx_head), .full(busy), .empty(rx_empty)
  );

  atc_fifo #(.WIDTH(`ATC_PLANE_ID_W), .DEPTH(`ATC_FIFO_DEPTH)) takeoff_fifo (
    .clock, .reset_n, .data_in(push_id), .push(takeoff_push), .pop(takeoff_pop),
    .head(takeoff_head), .full(takeoff_full), .empty(takeoff_empty)
  );

  atc_fifo #(.WIDTH(`ATC_PLANE_ID_W), .DEPTH(`ATC_FIFO_DEPTH)) landing_fifo (
    .clock, .reset_n, .data_in(push_id), .push(landing_push), .pop(landing_pop),
    .head(landing_head), .full(landing_full), .empty(landing_empty)
  );

  atc_fifo #(.WIDTH(`ATC_MSG_W), .DEPTH(`ATC_FIFO_DEPTH)) reply_fifo (
    .clock, .reset_n, .data_in(reply), .push(reply_push), .pop(reply_pop),
    .head(reply_head), .full(reply_full), .empty(reply_empty)
  );

  //////////////////////////////////////////////////
  // Control, runways and UART transmit
  //////////////////////////////////////////////////

  atc_request_ctrl i_request_ctrl (
    .clock, .reset_n, .rx_msg(rx_head), .rx_empty, .rx_pop,
    .takeoff_head, .landing_head, .takeoff_full, .takeoff_empty,
    .landing_full, .landing_empty, .takeoff_push, .takeoff_pop,
    .landing_push, .landing_pop, .push_id, .runway_active,
    .lock, .release_req, .runway, .lock_id, .reply, .reply_full, .reply_push
  );

  runway_table i_runway_table (
    .clock, .reset_n, .lock, .release_req, .runway, .plane_id(lock_id), .runway_active
  );

  atc_tx_sender i_tx_sender (
    .clock, .reset_n, .reply_head, .reply_empty, .reply_pop,
    .uart_tx_ready, .uart_tx_data, .uart_tx_send
  );

endmodule

`default_nettype wire

//--- hw/atc_tx_sender.sv
//////////////////////////////////////////////////
// Reply sender
// Moves replies from the reply FIFO to the UART
//////////////////////////////////////////////////

`default_nettype none

module atc_tx_sender
  import atc_msg_pkg::*;
(
  input  logic clock,
  input  logic reset_n,
  input  msg_t reply_head,
  input  logic reply_empty,
  output logic reply_pop,
  input  logic uart_tx_ready,
  output msg_t uart_tx_data,
  output logic uart_tx_send
);

  typedef enum logic {S_WAIT, S_SEND} sender_state_t;

  sender_state_t state;

  assign reply_pop    = (state == S_WAIT) && !reply_empty && uart_tx_ready;
  assign uart_tx_send = (state == S_SEND);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= S_WAIT;
    end else if (state == S_SEND) begin
      state <= S_WAIT;
    end else if (reply_pop) begin
      state <= S_SEND;
    end
  end

  // Data held steady through the send cycle
  always_ff @(posedge clock) begin
    if (reply_pop) begin
      uart_tx_data <= reply_head;
    end
  end

endmodule

`default_nettype wire

//--- hw/tower_ctrl/atc_request_ctrl.sv
//////////////////////////////////////////////////
// Request controller
// Decodes plane messages, queues planes, clears
// them onto free runways and builds the replies
//////////////////////////////////////////////////

`default_nettype none

`include "atc_macros.svh"

module atc_request_ctrl
  import atc_msg_pkg::*, atc_ctrl_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset_n,
  input  msg_t                       rx_msg,
  input  logic                       rx_empty,
  output logic                       rx_pop,
  input  logic [`ATC_PLANE_ID_W-1:0] takeoff_head,
  input  logic [`ATC_PLANE_ID_W-1:0] landing_head,
  input  logic                       takeoff_full,
  input  logic                       takeoff_empty,
  input  logic                       landing_full,
  input  logic                       landing_empty,
  output logic                       takeoff_push,
  output logic                       takeoff_pop,
  output logic                       landing_push,
  output logic                       landing_pop,
  output logic [`ATC_PLANE_ID_W-1:0] push_id,
  input  logic [1:0]                 runway_active,
  output logic                       lock,
  output logic                       release_req,
  output logic                       runway,
  output logic [`ATC_PLANE_ID_W-1:0] lock_id,
  output msg_t                       reply,
  input  logic                       reply_full,
  output logic                       reply_push
);

  ctrl_state_t state, next_state;
  msg_t        msg_q;
  reply_kind_t kind_d, kind_q, reply_kind;
  logic        takeoff_first;
  logic        pick_takeoff, pick_takeoff_q;
  logic        runway_q;
  logic [`ATC_PLANE_ID_W-1:0] clear_id;

  // Takeoff wins a tie when the alternation bit is set
  assign pick_takeoff = !takeoff_empty && (landing_empty || takeoff_first);
  assign clear_id     = pick_takeoff_q ? takeoff_head : landing_head;

  // DECODE serves the message's plane, CLEAR the chosen queue head
  assign push_id    = msg_q.plane_id;
  assign lock_id    = (state == CLEAR) ? clear_id : msg_q.plane_id;
  assign runway     = (state == CLEAR) ? runway_q : msg_q.action[0];
  assign reply_kind = (state == CLEAR) ? R_CLEAR : kind_q;

  //////////////////////////////////////////////////
  // Next state and commands
  //////////////////////////////////////////////////

  always_comb begin
    next_state   = state;
    kind_d       = R_SAY_AGAIN;
    rx_pop       = 1'b0;
    takeoff_push = 1'b0;
    takeoff_pop  = 1'b0;
    landing_push = 1'b0;
    landing_pop  = 1'b0;
    lock         = 1'b0;
    release_req  = 1'b0;
    reply_push   = 1'b0;
    case (state)
      IDLE: begin
        if (!rx_empty) begin
          rx_pop     = 1'b1;
          next_state = DECODE;
        end
      end
      DECODE: begin
        next_state = REPLY;
        case (msg_q.msg_type)
          T_REQUEST: begin
            // action[1] set means landing
            if (msg_q.action[1]) begin
              kind_d       = landing_full ? R_DIVERT : R_HOLD;
              landing_push = !landing_full;
            end else begin
              kind_d       = takeoff_full ? R_DIVERT : R_HOLD;
              takeoff_push = !takeoff_full;
            end
          end
          T_DECLARE: begin
            release_req = 1'b1;
            next_state  = PICK;
          end
          default: kind_d = R_SAY_AGAIN;
        endcase
      end
      REPLY: begin
        if (!reply_full) begin
          reply_push = 1'b1;
          next_state = PICK;
        end
      end
      PICK: begin
        if ((takeoff_empty && landing_empty) || (&runway_active)) begin
          next_state = IDLE;
        end else begin
          next_state = CLEAR;
        end
      end
      CLEAR: begin
        // Plane leaves its queue only once the reply is accepted
        if (!reply_full) begin
          lock        = 1'b1;
          takeoff_pop = pick_takeoff_q;
          landing_pop = !pick_takeoff_q;
          reply_push  = 1'b1;
          next_state  = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state         <= IDLE;
      takeoff_first <= 1'b1;
    end else begin
      state <= next_state;
      if (state == CLEAR && !reply_full) begin
        takeoff_first <= !takeoff_first;
      end
    end
  end

  // Message, reply kind and clearance choice
  always_ff @(posedge clock) begin
    if (rx_pop) begin
      msg_q <= rx_msg;
    end
    if (state == DECODE) begin
      kind_q <= kind_d;
    end
    if (state == PICK) begin
      pick_takeoff_q <= pick_takeoff;
      // Lowest-numbered free runway
      runway_q       <= runway_active[0];
    end
  end

  //////////////////////////////////////////////////
  // Reply builder
  //////////////////////////////////////////////////

  always_comb begin
    reply.plane_id = msg_q.plane_id;
    reply.msg_type = T_SAY_AGAIN;
    reply.action   = 2'b00;
    case (reply_kind)
      R_HOLD:      reply.msg_type = T_HOLD;
      R_DIVERT:    reply.msg_type = T_DIVERT;
      R_SAY_AGAIN: reply.msg_type = T_SAY_AGAIN;
      R_CLEAR: begin
        reply.plane_id = clear_id;
        reply.msg_type = T_CLEAR;
        reply.action   = {1'b0, runway_q};
      end
      default: reply.msg_type = T_SAY_AGAIN;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/tower_ctrl/runway_table.sv
//////////////////////////////////////////////////
// Runway table
// Holder and busy flag for each of two runways
//////////////////////////////////////////////////

`default_nettype none

`include "atc_macros.svh"

module runway_table (
  input  logic                       clock,
  input  logic                       reset_n,
  input  logic                       lock,
  input  logic                       release_req,
  input  logic                       runway,
  input  logic [`ATC_PLANE_ID_W-1:0] plane_id,
  output logic [1:0]                 runway_active
);

  logic [`ATC_PLANE_ID_W-1:0] holder [2];
  logic                       holder_match;

  // Only the plane on the runway may free it
  assign holder_match = (plane_id == holder[runway]);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      runway_active <= 2'b00;
    end else if (lock) begin
      runway_active[runway] <= 1'b1;
    end else if (release_req && holder_match) begin
      runway_active[runway] <= 1'b0;
    end
  end

  // Holder id, valid while the runway is active
  always_ff @(posedge clock) begin
    if (lock) begin
      holder[runway] <= plane_id;
    end
  end

endmodule

`default_nettype wire
